// ==== verilog/rsPkg.sv ====
`default_nettype none

package rsPkg;

    localparam int numForward = 3;          // Result buses feeding wakeup

    typedef logic [31:0] dataWord;
    typedef logic [5:0]  physReg;
    typedef logic [5:0]  robTag;
    typedef logic [3:0]  aluCtrl;

    typedef enum logic [1:0] {
        fuAlu0,
        fuAlu1,
        fuMem
    } fuKind;

    typedef enum logic {
        memIdle,
        memBusy
    } memState;

    // One dispatched instruction as it sits in a station slot
    typedef struct packed {
        logic    valid;
        robTag   robNum;
        fuKind   fu;
        physReg  rd;
        physReg  rs1;
        physReg  rs2;
        logic    rs1Rdy;
        logic    rs2Rdy;
        dataWord rs1Data;
        dataWord rs2Data;
        aluCtrl  op;
        dataWord imm;
    } dispatchEntry;

    typedef struct packed {
        logic    valid;
        physReg  regAddr;
        dataWord data;
    } forwardBus;

    typedef struct packed {
        logic    valid;
        robTag   robNum;
        physReg  rd;
        dataWord src1;
        dataWord src2;
        aluCtrl  op;
        dataWord imm;
    } issuePacket;

endpackage

`default_nettype wire

// ==== verilog/dispatchDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatchDecoder #(
    parameter int numEntries = 16,
    localparam int idxWidth = $clog2(numEntries)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  rsPkg::dispatchEntry   dispatchA,
    input  rsPkg::dispatchEntry   dispatchB,
    output logic [numEntries-1:0] slotWrite,
    output rsPkg::dispatchEntry   slotData [numEntries],
    output logic [idxWidth-1:0]   scanBase
);
    import rsPkg::*;

    logic [idxWidth-1:0] idxA;
    logic [idxWidth-1:0] idxB;
    logic [1:0]          dispatchCount;

    assign idxA = dispatchA.robNum[idxWidth-1:0];   // ROB number modulo slot count
    assign idxB = dispatchB.robNum[idxWidth-1:0];
    assign dispatchCount = 2'(dispatchA.valid) + 2'(dispatchB.valid);

    always_comb begin
        slotWrite = '0;
        for (int i = 0; i < numEntries; i++) begin
            slotData[i] = dispatchA;                // Don't care without write
        end
        if (dispatchB.valid) begin
            slotWrite[idxB] = 1'b1;
            slotData[idxB]  = dispatchB;
        end
        if (dispatchA.valid) begin                  // A overrides B on a shared slot
            slotWrite[idxA] = 1'b1;
            slotData[idxA]  = dispatchA;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scanBase <= '0;
        end else begin
            scanBase <= scanBase + idxWidth'(dispatchCount);   // Wraps at numEntries
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rsSlot.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsSlot (
    input  logic                clk,
    input  logic                reset,
    input  logic                write,
    input  rsPkg::dispatchEntry writeData,
    input  rsPkg::forwardBus    forward [rsPkg::numForward],
    input  logic                grant,
    output rsPkg::dispatchEntry entry,
    output logic                ready
);
    import rsPkg::*;

    logic [numForward-1:0] hit1;    // Per-bus tag match on source 1
    logic [numForward-1:0] hit2;

    always_comb begin
        for (int i = 0; i < numForward; i++) begin
            hit1[i] = forward[i].valid && !entry.rs1Rdy && (forward[i].regAddr == entry.rs1);
            hit2[i] = forward[i].valid && !entry.rs2Rdy && (forward[i].regAddr == entry.rs2);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entry.valid  <= 1'b0;
            entry.rs1Rdy <= 1'b0;
            entry.rs2Rdy <= 1'b0;
        end else if (write) begin
            entry <= writeData;                     // Forwards this cycle are ignored
        end else if (grant) begin
            entry.valid  <= 1'b0;
            entry.rs1Rdy <= 1'b0;
            entry.rs2Rdy <= 1'b0;
        end else if (entry.valid) begin
            // Later buses take priority on a multiple match
            for (int i = 0; i < numForward; i++) begin
                if (hit1[i]) begin
                    entry.rs1Rdy  <= 1'b1;
                    entry.rs1Data <= forward[i].data;
                end
                if (hit2[i]) begin
                    entry.rs2Rdy  <= 1'b1;
                    entry.rs2Data <= forward[i].data;
                end
            end
        end
    end

    assign ready = entry.valid && entry.rs1Rdy && entry.rs2Rdy;

endmodule

`default_nettype wire

// ==== verilog/issueSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueSelect #(
    parameter int numEntries = 16,
    localparam int idxWidth = $clog2(numEntries)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  rsPkg::dispatchEntry   slotEntries [numEntries],
    input  logic [numEntries-1:0] slotReady,
    input  logic [idxWidth-1:0]   scanBase,
    output logic [numEntries-1:0] grant,
    output rsPkg::issuePacket     issueAlu0,
    output rsPkg::issuePacket     issueAlu1,
    output rsPkg::issuePacket     issueMem
);
    import rsPkg::*;

    localparam int numUnits = 3;

    logic [numEntries-1:0] request [numUnits];  // Ready slots per unit
    logic [idxWidth:0]     pick [numUnits];     // Found flag over slot index
    memState               memStatus;

    // First set request bit at or after base, wrapping around
    function automatic logic [idxWidth:0] pickFirst(input logic [numEntries-1:0] req,
                                                    input logic [idxWidth-1:0] base);
        logic [idxWidth:0]   result;
        logic [idxWidth-1:0] idx;
        result = '0;
        for (int k = numEntries - 1; k >= 0; k--) begin
            idx = base + idxWidth'(k);
            if (req[idx]) begin
                result = {1'b1, idx};
            end
        end
        return result;
    endfunction

    function automatic issuePacket toPacket(input dispatchEntry e, input logic found);
        issuePacket p;
        p.valid  = found;
        p.robNum = e.robNum;
        p.rd     = e.rd;
        p.src1   = e.rs1Data;
        p.src2   = e.rs2Data;
        p.op     = e.op;
        p.imm    = e.imm;
        return p;
    endfunction

    always_comb begin
        for (int u = 0; u < numUnits; u++) begin
            for (int i = 0; i < numEntries; i++) begin
                request[u][i] = slotReady[i] && (slotEntries[i].fu == fuKind'(u));
            end
        end
        if (memStatus == memBusy) begin
            request[fuMem] = '0;                    // Memory unit still occupied
        end
    end

    always_comb begin
        for (int u = 0; u < numUnits; u++) begin
            pick[u] = pickFirst(request[u], scanBase);
        end
    end

    // Units never share a slot since each slot targets one fu
    always_comb begin
        grant = '0;
        for (int u = 0; u < numUnits; u++) begin
            if (pick[u][idxWidth]) begin
                grant[pick[u][idxWidth-1:0]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issueAlu0.valid <= 1'b0;
            issueAlu1.valid <= 1'b0;
            issueMem.valid  <= 1'b0;
            memStatus       <= memIdle;
        end else begin
            issueAlu0 <= toPacket(slotEntries[pick[fuAlu0][idxWidth-1:0]], pick[fuAlu0][idxWidth]);
            issueAlu1 <= toPacket(slotEntries[pick[fuAlu1][idxWidth-1:0]], pick[fuAlu1][idxWidth]);
            issueMem  <= toPacket(slotEntries[pick[fuMem][idxWidth-1:0]], pick[fuMem][idxWidth]);
            case (memStatus)
                memIdle: begin
                    if (pick[fuMem][idxWidth]) begin
                        memStatus <= memBusy;       // Blocks the next cycle's grant
                    end
                end
                memBusy: begin
                    memStatus <= memIdle;
                end
                default: begin
                    memStatus <= memIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reservationStation.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservationStation #(
    parameter int numEntries = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  rsPkg::dispatchEntry dispatchA,
    input  rsPkg::dispatchEntry dispatchB,
    input  rsPkg::forwardBus    forward [rsPkg::numForward],
    output rsPkg::issuePacket   issueAlu0,
    output rsPkg::issuePacket   issueAlu1,
    output rsPkg::issuePacket   issueMem
);
    import rsPkg::*;

    localparam int idxWidth = $clog2(numEntries);

    logic [numEntries-1:0] slotWrite;
    logic [numEntries-1:0] slotReady;
    logic [numEntries-1:0] grant;
    logic [idxWidth-1:0]   scanBase;      // Where the issue search starts

    dispatchEntry slotData [numEntries];    // Entry to load on write
    dispatchEntry slotEntries [numEntries]; // Current slot contents

    dispatchDecoder #(
        .numEntries(numEntries)
    ) i_dispatchDecoder (
        .clk,
        .reset,
        .dispatchA,
        .dispatchB,
        .slotWrite,
        .slotData,
        .scanBase
    );

    for (genvar i = 0; i < numEntries; i++) begin : slotGen
        rsSlot i_rsSlot (
            .clk,
            .reset,
            .write(slotWrite[i]),
            .writeData(slotData[i]),
            .forward,
            .grant(grant[i]),
            .entry(slotEntries[i]),
            .ready(slotReady[i])
        );
    end

    issueSelect #(
        .numEntries(numEntries)
    ) i_issueSelect (
        .clk,
        .reset,
        .slotEntries,
        .slotReady,
        .scanBase,
        .grant,
        .issueAlu0,
        .issueAlu1,
        .issueMem
    );

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int halfPeriod = 5    // 10 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(halfPeriod);
        clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verification/rsChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsChecker (
    input  logic              clk,
    input  logic              checkEn,
    input  logic              done,
    input  int                testNum,
    input  rsPkg::issuePacket issueAlu0,
    input  rsPkg::issuePacket issueAlu1,
    input  rsPkg::issuePacket issueMem,
    input  rsPkg::issuePacket expIssue [3],   // Port order alu0, alu1, mem
    output int                errorCount
);
    import rsPkg::*;

    issuePacket got [3];
    string      portName [3] = '{"issueAlu0", "issueAlu1", "issueMem"};
    int         curTest = -1;
    int         testErrors = 0;
    int         testsPassed = 0;
    int         testsFailed = 0;

    assign got[0] = issueAlu0;
    assign got[1] = issueAlu1;
    assign got[2] = issueMem;

    initial begin
        errorCount = 0;
    end

    task automatic closeTest();
        if (curTest >= 0) begin
            if (testErrors == 0) begin
                testsPassed++;
                $display("Test %0d passed", curTest);
            end else begin
                testsFailed++;
                $display("Test %0d failed with %0d errors", curTest, testErrors);
            end
        end
        testErrors = 0;
    endtask

    task automatic reportValue(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("Error at %0t: %s expected %0h got %0h", $time, sig, expected, actual);
        testErrors++;
        errorCount++;
    endtask

    task automatic compareField(input string sig, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            reportValue(sig, expected, actual);
        end
    endtask

    // Outputs are stable between edges, so compare mid-cycle
    always @(negedge clk) begin
        if (checkEn) begin
            if (testNum != curTest) begin
                closeTest();
                curTest = testNum;
            end
            for (int p = 0; p < 3; p++) begin
                if (got[p].valid !== expIssue[p].valid) begin
                    reportValue({portName[p], ".valid"}, 32'(expIssue[p].valid),
                                32'(got[p].valid));
                end else if (expIssue[p].valid) begin
                    compareField({portName[p], ".robNum"}, 32'(expIssue[p].robNum),
                                 32'(got[p].robNum));
                    compareField({portName[p], ".rd"}, 32'(expIssue[p].rd), 32'(got[p].rd));
                    compareField({portName[p], ".src1"}, expIssue[p].src1, got[p].src1);
                    compareField({portName[p], ".src2"}, expIssue[p].src2, got[p].src2);
                    compareField({portName[p], ".op"}, 32'(expIssue[p].op), 32'(got[p].op));
                    compareField({portName[p], ".imm"}, expIssue[p].imm, got[p].imm);
                end
            end
        end
    end

    always @(posedge done) begin
        closeTest();
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 testsPassed, testsFailed, errorCount);
    end

endmodule

`default_nettype wire

// ==== verification/tbReservationStation.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbReservationStation;
    import rsPkg::*;

    localparam int numRows = 40;
    localparam int cycleLimit = numRows + 20;

    logic         clk;
    logic         reset;
    logic         checkEn;
    logic         done;
    int           testNum;
    int           errorCount;
    int           cycles;
    int           seed = 55766;
    dispatchEntry dispA;
    dispatchEntry dispB;
    forwardBus    fwd [numForward];
    issuePacket   issueAlu0;
    issuePacket   issueAlu1;
    issuePacket   issueMem;
    issuePacket   curExp [3];

    // Stimulus and expected outputs, one row per cycle
    dispatchEntry rowA [numRows];
    dispatchEntry rowB [numRows];
    forwardBus    rowFwd [numRows][numForward];
    issuePacket   rowExp [numRows][3];
    int           rowTest [numRows];

    tbClock i_tbClock (.clk);

    reservationStation #(
        .numEntries(16)
    ) i_reservationStation (
        .clk,
        .reset,
        .dispatchA(dispA),
        .dispatchB(dispB),
        .forward(fwd),
        .issueAlu0,
        .issueAlu1,
        .issueMem
    );

    rsChecker i_rsChecker (
        .clk,
        .checkEn,
        .done,
        .testNum,
        .issueAlu0,
        .issueAlu1,
        .issueMem,
        .expIssue(curExp),
        .errorCount
    );

    function automatic dataWord nextWord();
        return dataWord'($random(seed));
    endfunction

    // Source 2 always arrives ready with random data
    task automatic putDispatch(input int r, input bit toB, input int rob, input fuKind fu,
                               input int rs1Tag, input bit rs1Ready, input dataWord rs1Value);
        dispatchEntry e;
        e = '0;
        e.valid   = 1'b1;
        e.robNum  = robTag'(rob);
        e.fu      = fu;
        e.rd      = physReg'(rob);
        e.rs1     = physReg'(rs1Tag);
        e.rs1Rdy  = rs1Ready;
        e.rs1Data = rs1Ready ? rs1Value : '0;
        e.rs2Rdy  = 1'b1;
        e.rs2Data = nextWord();
        e.op      = aluCtrl'(nextWord());
        e.imm     = nextWord();
        if (toB) begin
            rowB[r] = e;
        end else begin
            rowA[r] = e;
        end
    endtask

    task automatic putForward(input int r, input int bus, input int tag, input dataWord data);
        rowFwd[r][bus] = '{valid: 1'b1, regAddr: physReg'(tag), data: data};
    endtask

    // Issued packet carries the dispatched fields with source 1 as delivered
    task automatic expectIssue(input int r, input int port, input dispatchEntry e,
                               input dataWord src1);
        rowExp[r][port] = '{valid: 1'b1, robNum: e.robNum, rd: e.rd, src1: src1,
                            src2: e.rs2Data, op: e.op, imm: e.imm};
    endtask

    task automatic buildTable();
        dataWord w0;
        dataWord w1;
        for (int r = 0; r < numRows; r++) begin
            rowA[r] = '0;
            rowB[r] = '0;
            for (int b = 0; b < numForward; b++) begin
                rowFwd[r][b] = '0;
            end
            for (int p = 0; p < 3; p++) begin
                rowExp[r][p] = '0;
            end
            rowTest[r] = (r < 3) ? 1 : (r < 6) ? 2 : (r < 12) ? 3 : (r < 16) ? 4 :
                         (r < 21) ? 5 : 6;
        end
        // Ready ALU instruction issues once
        w0 = nextWord();
        putDispatch(3, 0, 1, fuAlu0, 0, 1, w0);
        expectIssue(4, 0, rowA[3], w0);
        // Two-tag wakeup, same-cycle forward ignored
        putDispatch(6, 0, 2, fuAlu1, 10, 0, '0);
        rowA[6].rs2 = 6'd11;
        rowA[6].rs2Rdy = 1'b0;
        putForward(6, 0, 10, nextWord());
        w0 = nextWord();
        putForward(8, 1, 10, w0);
        w1 = nextWord();
        putForward(9, 2, 11, w1);
        expectIssue(10, 1, rowA[6], w0);
        rowExp[10][1].src2 = w1;                    // Source 2 woken by bus 2
        // Dual dispatch, scanBase 4 puts slot 4 ahead of slot 3
        w0 = nextWord();
        w1 = nextWord();
        putDispatch(12, 0, 20, fuAlu0, 0, 1, w0);
        putDispatch(12, 1, 19, fuAlu0, 0, 1, w1);
        expectIssue(13, 0, rowA[12], w0);
        expectIssue(14, 0, rowB[12], w1);
        // Memory gap with ALU issue in the idle cycle
        w0 = nextWord();
        w1 = nextWord();
        putDispatch(16, 0, 5, fuMem, 0, 1, w0);
        putDispatch(16, 1, 6, fuMem, 0, 1, w1);
        expectIssue(17, 2, rowB[16], w1);
        expectIssue(19, 2, rowA[16], w0);
        w1 = nextWord();
        putDispatch(17, 0, 7, fuAlu0, 0, 1, w1);
        expectIssue(18, 0, rowA[17], w1);
        // Mixed sequence
        w0 = nextWord();
        w1 = nextWord();
        putDispatch(21, 0, 8, fuAlu0, 0, 1, w0);
        putDispatch(21, 1, 9, fuAlu1, 0, 1, w1);
        expectIssue(22, 0, rowA[21], w0);
        expectIssue(22, 1, rowB[21], w1);
        putDispatch(22, 0, 10, fuMem, 20, 0, '0);
        putDispatch(22, 1, 11, fuAlu0, 21, 0, '0);
        w0 = nextWord();
        putDispatch(23, 0, 12, fuMem, 0, 1, w0);
        expectIssue(24, 2, rowA[23], w0);
        w0 = nextWord();
        w1 = nextWord();
        putForward(24, 0, 20, w0);
        putForward(24, 2, 21, w1);
        expectIssue(25, 0, rowB[22], w1);
        expectIssue(26, 2, rowA[22], w0);
        w0 = nextWord();
        putDispatch(25, 0, 13, fuAlu1, 0, 1, w0);
        expectIssue(26, 1, rowA[25], w0);
        putDispatch(26, 0, 14, fuAlu0, 30, 0, '0);
        putForward(27, 0, 30, nextWord());
        w1 = nextWord();
        putForward(27, 1, 30, w1);                  // Higher bus wins
        expectIssue(28, 0, rowA[26], w1);
        w0 = nextWord();
        w1 = nextWord();
        putDispatch(28, 0, 15, fuMem, 0, 1, w0);
        putDispatch(28, 1, 16, fuMem, 0, 1, w1);
        expectIssue(29, 2, rowB[28], w1);
        expectIssue(31, 2, rowA[28], w0);
        w0 = nextWord();
        w1 = nextWord();
        putDispatch(29, 0, 17, fuAlu1, 0, 1, w0);
        putDispatch(29, 1, 18, fuAlu1, 0, 1, w1);
        expectIssue(30, 1, rowB[29], w1);
        expectIssue(31, 1, rowA[29], w0);
        w0 = nextWord();
        w1 = nextWord();
        putDispatch(32, 0, 19, fuAlu0, 0, 1, w0);
        putDispatch(32, 1, 20, fuAlu1, 0, 1, w1);
        expectIssue(33, 0, rowA[32], w0);
        expectIssue(33, 1, rowB[32], w1);
        putDispatch(33, 0, 21, fuAlu0, 40, 0, '0);
        putForward(33, 1, 40, nextWord());
        w0 = nextWord();
        putForward(35, 2, 40, w0);
        expectIssue(36, 0, rowA[33], w0);
        w1 = nextWord();
        putDispatch(36, 0, 22, fuMem, 0, 1, w1);
        expectIssue(37, 2, rowA[36], w1);
    endtask

    task automatic applyRow(input int r);
        if (r < numRows) begin
            dispA = rowA[r];
            dispB = rowB[r];
            fwd   = rowFwd[r];
        end else begin
            dispA = '0;
            dispB = '0;
            for (int b = 0; b < numForward; b++) begin
                fwd[b] = '0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            cycles <= cycles + 1;
            if (cycles > cycleLimit) begin
                $display("Run did not finish within %0d cycles", cycleLimit);
                $display("*** TEST FAILED ***");
                $finish;
            end
        end
    end

    initial begin
        reset   = 1'b1;
        checkEn = 1'b0;
        done    = 1'b0;
        testNum = 0;
        cycles  = 0;
        for (int p = 0; p < 3; p++) begin
            curExp[p] = '0;
        end
        applyRow(numRows);
        buildTable();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int r = 0; r <= numRows; r++) begin
            applyRow(r);
            if (r > 0) begin                        // Outputs now reflect row r-1
                testNum = rowTest[r-1];
                for (int p = 0; p < 3; p++) begin
                    curExp[p] = rowExp[r-1][p];
                end
                checkEn = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        checkEn = 1'b0;
        done = 1'b1;
        #2;
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/rsPkg.sv
verilog/dispatchDecoder.sv
verilog/rsSlot.sv
verilog/issueSelect.sv
verilog/reservationStation.sv
verification/tbClock.sv
verification/rsChecker.sv
verification/tbReservationStation.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wall -Wno-fatal -f build.f \
    --top-module tbReservationStation -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
